/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_dcache
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

SRCS := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bus_pkg.sv */
package bus_pkg;

    localparam int WORD_BITS = 32;
    localparam int STROBE_BITS = WORD_BITS / 8;
    // tag and index, the byte address without the line offset
    localparam int LINE_ADDR_BITS = 28;

    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [WORD_BITS-1:0] addr_t;
    typedef logic [STROBE_BITS-1:0] strobe_t;
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;

    // zero strobe is a read
    typedef struct packed {
        logic valid;
        addr_t addr;
        strobe_t strobe;
        word_t data;
    } cpu_req_t;

    typedef struct packed {
        logic addr_ok;
        logic data_ok;
        word_t data;
    } cpu_resp_t;

    typedef struct packed {
        logic valid;
        logic is_write;
        line_addr_t line_addr;
        word_t data;
    } mem_req_t;

    typedef struct packed {
        logic ready;
        logic last;
        word_t data;
    } mem_resp_t;

endpackage

/* cache_geom_pkg.sv */
package cache_geom_pkg;

    localparam int ADDR_BITS = 32;
    localparam int WAYS = 2;
    localparam int SETS = 16;
    localparam int LINE_WORDS = 4;
    localparam int BYTES_PER_WORD = 4;

    localparam int WAY_BITS = $clog2(WAYS);
    localparam int OFFSET_BITS = $clog2(LINE_WORDS);
    localparam int ALIGN_BITS = $clog2(BYTES_PER_WORD);
    localparam int INDEX_BITS = $clog2(SETS);
    localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - OFFSET_BITS - ALIGN_BITS;

    typedef logic [WAY_BITS-1:0] way_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;
    typedef logic [ALIGN_BITS-1:0] align_t;
    typedef logic [TAG_BITS-1:0] tag_t;

    typedef struct packed {
        tag_t tag;
        index_t index;
        offset_t offset;
        align_t align;
    } addr_fields_t;

    // word slot in the data array
    typedef struct packed {
        way_t way;
        index_t index;
        offset_t offset;
    } data_addr_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } meta_t;

    typedef struct packed {
        logic hit;
        way_t hit_way;
        way_t victim_way;
        logic victim_dirty;
        tag_t victim_tag;
    } lookup_t;

endpackage

/* data_store.sv */
`timescale 1ns/1ps

module data_store (
    input  logic                       clk,
    input  logic                       en,
    input  bus_pkg::strobe_t           wstrobe,
    input  cache_geom_pkg::data_addr_t addr,
    input  bus_pkg::word_t             wdata,
    output bus_pkg::word_t             rdata
);
    import cache_geom_pkg::*;
    import bus_pkg::*;

    localparam int DEPTH = WAYS * SETS * LINE_WORDS;

    word_t words [DEPTH];

    // read returns the word as it was before this cycle's write
    always_ff @(posedge clk) begin
        if (en) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                if (wstrobe[b]) begin
                    words[addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
            rdata <= words[addr];
        end
    end

endmodule

/* dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
    input  logic               clk,
    input  logic               resetn,
    input  bus_pkg::cpu_req_t  cpu_req,
    output bus_pkg::cpu_resp_t cpu_resp,
    output bus_pkg::mem_req_t  mem_req,
    input  bus_pkg::mem_resp_t mem_resp
);
    import cache_geom_pkg::*;
    import bus_pkg::*;

    addr_fields_t lookup_addr;
    lookup_t lookup;

    logic upd_en;
    logic upd_refill;
    logic upd_write;
    way_t upd_way;
    index_t upd_index;
    tag_t upd_tag;

    logic ram_en;
    strobe_t ram_wstrobe;
    data_addr_t ram_addr;
    word_t ram_wdata;
    word_t ram_rdata;

    // tags are looked up straight from the request on the bus
    assign lookup_addr = cpu_req.addr;

    tag_store u_tag_store (
        .clk        (clk),
        .resetn     (resetn),
        .lookup_addr(lookup_addr),
        .result     (lookup),
        .upd_en     (upd_en),
        .upd_refill (upd_refill),
        .upd_write  (upd_write),
        .upd_way    (upd_way),
        .upd_index  (upd_index),
        .upd_tag    (upd_tag)
    );

    data_store u_data_store (
        .clk    (clk),
        .en     (ram_en),
        .wstrobe(ram_wstrobe),
        .addr   (ram_addr),
        .wdata  (ram_wdata),
        .rdata  (ram_rdata)
    );

    miss_controller u_miss_controller (
        .clk        (clk),
        .resetn     (resetn),
        .req        (cpu_req),
        .lookup     (lookup),
        .resp       (cpu_resp),
        .upd_en     (upd_en),
        .upd_refill (upd_refill),
        .upd_write  (upd_write),
        .upd_way    (upd_way),
        .upd_index  (upd_index),
        .upd_tag    (upd_tag),
        .ram_en     (ram_en),
        .ram_wstrobe(ram_wstrobe),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),
        .ram_rdata  (ram_rdata),
        .mem_req    (mem_req),
        .mem_resp   (mem_resp)
    );

endmodule

/* filelist.f */
cache_geom_pkg.sv
bus_pkg.sv
tag_store.sv
data_store.sv
miss_controller.sv
dcache_top.sv
mem_model.sv
tb_dcache.sv

/* mem_model.sv */
`timescale 1ns/1ps

module mem_model #(
    parameter logic [31:0] BASE = 32'h8000_0000
) (
    input  logic               clk,
    input  logic               resetn,
    input  logic               hold,
    input  bus_pkg::mem_req_t  mem_req,
    output bus_pkg::mem_resp_t mem_resp
);
    import cache_geom_pkg::*;
    import bus_pkg::*;

    localparam int WORDS = 1024;

    word_t words [WORDS];
    offset_t beat;
    logic [9:0] idx;

    function automatic word_t preset_word(input word_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            words[i] = preset_word(BASE | (word_t'(i) << 2));
        end
    end

    // only a 4 KB window above BASE is backed
    assign idx = {mem_req.line_addr[7:0], beat};

    always_comb begin
        mem_resp.ready = mem_req.valid && !hold;
        mem_resp.last = mem_resp.ready && (beat == offset_t'(LINE_WORDS - 1));
        mem_resp.data = words[idx];
    end

    // beat wraps to zero after the last one
    always @(posedge clk) begin
        if (resetn) begin
            beat <= '0;
        end else if (mem_resp.ready) begin
            beat <= beat + offset_t'(1);
            if (mem_req.is_write) begin
                words[idx] <= mem_req.data;
            end
        end
    end

endmodule

/* miss_controller.sv */
`timescale 1ns/1ps

module miss_controller (
    input  logic                       clk,
    input  logic                       resetn,
    input  bus_pkg::cpu_req_t          req,
    input  cache_geom_pkg::lookup_t    lookup,
    output bus_pkg::cpu_resp_t         resp,
    output logic                       upd_en,
    output logic                       upd_refill,
    output logic                       upd_write,
    output cache_geom_pkg::way_t       upd_way,
    output cache_geom_pkg::index_t     upd_index,
    output cache_geom_pkg::tag_t       upd_tag,
    output logic                       ram_en,
    output bus_pkg::strobe_t           ram_wstrobe,
    output cache_geom_pkg::data_addr_t ram_addr,
    output bus_pkg::word_t             ram_wdata,
    input  bus_pkg::word_t             ram_rdata,
    output bus_pkg::mem_req_t          mem_req,
    input  bus_pkg::mem_resp_t         mem_resp
);
    import cache_geom_pkg::*;
    import bus_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        EVICT_READ,
        WRITEBACK,
        REFILL,
        REPLAY
    } state_t;

    state_t state;
    logic en;
    logic proc_valid;
    cpu_req_t proc_req;
    lookup_t proc_lookup;
    addr_fields_t proc_addr;
    logic hit_now;
    logic miss_now;
    logic [OFFSET_BITS:0] cnt;
    offset_t beat;
    word_t line_buf [LINE_WORDS];
    logic data_ok_q;
    logic replay_q;

    assign proc_addr = proc_req.addr;
    assign hit_now = (state == IDLE) && proc_valid && proc_lookup.hit;
    assign miss_now = (state == IDLE) && proc_valid && !proc_lookup.hit;
    assign beat = cnt[OFFSET_BITS-1:0];

    // addr_ok drops after a missing accept, back after the replay's data_ok
    always_ff @(posedge clk) begin
        if (resetn) begin
            en <= 1'b1;
        end else if (en) begin
            en <= !(req.valid && !lookup.hit);
        end else begin
            en <= replay_q;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            proc_valid <= 1'b0;
        end else if (en) begin
            proc_valid <= req.valid;
        end else if (state == REPLAY) begin
            proc_valid <= 1'b0;
        end
    end

    // process stage, held while a miss is served
    always_ff @(posedge clk) begin
        if (en) begin
            proc_req <= req;
            proc_lookup <= lookup;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= IDLE;
            cnt <= '0;
        end else begin
            unique case (state)
                IDLE: begin
                    cnt <= '0;
                    if (miss_now) begin
                        state <= proc_lookup.victim_dirty ? EVICT_READ : REFILL;
                    end
                end
                EVICT_READ: begin
                    // msb set once the last read has landed
                    if (cnt[OFFSET_BITS]) begin
                        state <= WRITEBACK;
                        cnt <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                WRITEBACK: begin
                    if (mem_resp.ready) begin
                        cnt <= cnt + 1'b1;
                        if (mem_resp.last) begin
                            state <= REFILL;
                            cnt <= '0;
                        end
                    end
                end
                REFILL: begin
                    if (mem_resp.ready) begin
                        cnt <= cnt + 1'b1;
                        if (mem_resp.last) begin
                            state <= REPLAY;
                            cnt <= '0;
                        end
                    end
                end
                REPLAY: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // victim words arrive one cycle behind their read
    always_ff @(posedge clk) begin
        if (state == EVICT_READ && cnt != '0) begin
            line_buf[offset_t'(cnt - 1'b1)] <= ram_rdata;
        end
    end

    always_comb begin
        ram_en = 1'b0;
        ram_wstrobe = proc_req.strobe;
        ram_addr.way = proc_lookup.hit_way;
        ram_addr.index = proc_addr.index;
        ram_addr.offset = proc_addr.offset;
        ram_wdata = proc_req.data;
        unique case (state)
            IDLE: begin
                ram_en = hit_now;
            end
            EVICT_READ: begin
                ram_en = !cnt[OFFSET_BITS];
                ram_wstrobe = '0;
                ram_addr.way = proc_lookup.victim_way;
                ram_addr.offset = beat;
            end
            REFILL: begin
                ram_en = mem_resp.ready;
                ram_wstrobe = '1;
                ram_addr.way = proc_lookup.victim_way;
                ram_addr.offset = beat;
                ram_wdata = mem_resp.data;
            end
            REPLAY: begin
                ram_en = 1'b1;
                ram_addr.way = proc_lookup.victim_way;
            end
            default: begin
                ram_wstrobe = '0;
            end
        endcase
    end

    always_comb begin
        mem_req.valid = (state == WRITEBACK) || (state == REFILL);
        mem_req.is_write = (state == WRITEBACK);
        if (state == WRITEBACK) begin
            mem_req.line_addr = {proc_lookup.victim_tag, proc_addr.index};
        end else begin
            mem_req.line_addr = {proc_addr.tag, proc_addr.index};
        end
        mem_req.data = line_buf[beat];
    end

    // the refill update also covers the replayed access
    assign upd_en = hit_now || (state == REFILL && mem_resp.ready && mem_resp.last);
    assign upd_refill = (state == REFILL);
    assign upd_write = |proc_req.strobe;
    assign upd_way = (state == REFILL) ? proc_lookup.victim_way : proc_lookup.hit_way;
    assign upd_index = proc_addr.index;
    assign upd_tag = proc_addr.tag;

    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok_q <= 1'b0;
            replay_q <= 1'b0;
        end else begin
            data_ok_q <= hit_now || (state == REPLAY);
            replay_q <= (state == REPLAY);
        end
    end

    assign resp.addr_ok = en;
    assign resp.data_ok = data_ok_q;
    assign resp.data = ram_rdata;

endmodule

/* tag_store.sv */
`timescale 1ns/1ps

module tag_store (
    input  logic                         clk,
    input  logic                         resetn,
    input  cache_geom_pkg::addr_fields_t lookup_addr,
    output cache_geom_pkg::lookup_t      result,
    input  logic                         upd_en,
    input  logic                         upd_refill,
    input  logic                         upd_write,
    input  cache_geom_pkg::way_t         upd_way,
    input  cache_geom_pkg::index_t       upd_index,
    input  cache_geom_pkg::tag_t         upd_tag
);
    import cache_geom_pkg::*;

    tag_t tag_mem [WAYS][SETS];
    logic [WAYS-1:0][SETS-1:0] valid_q;
    logic [WAYS-1:0][SETS-1:0] dirty_q;
    logic [WAYS-1:0][SETS-1:0] dirty_n;
    way_t [SETS-1:0] lru_q;
    way_t [SETS-1:0] lru_n;

    meta_t [WAYS-1:0] rd_meta;
    logic [WAYS-1:0] hit_bits;
    way_t victim;

    // lru and dirty after this cycle's update
    always_comb begin
        dirty_n = dirty_q;
        lru_n = lru_q;
        if (upd_en) begin
            lru_n[upd_index] = ~upd_way;
            if (upd_refill) begin
                dirty_n[upd_way][upd_index] = upd_write;
            end else if (upd_write) begin
                dirty_n[upd_way][upd_index] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q <= '0;
        end else begin
            dirty_q <= dirty_n;
            lru_q <= lru_n;
            if (upd_en && upd_refill) begin
                valid_q[upd_way][upd_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (upd_en && upd_refill) begin
            tag_mem[upd_way][upd_index] <= upd_tag;
        end
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            rd_meta[w].valid = valid_q[w][lookup_addr.index];
            rd_meta[w].tag = tag_mem[w][lookup_addr.index];
            hit_bits[w] = rd_meta[w].valid && (rd_meta[w].tag == lookup_addr.tag);
        end
    end

    // a hit in the process stage this cycle already moves the victim
    assign victim = lru_n[lookup_addr.index];

    always_comb begin
        result = '0;
        result.hit = |hit_bits;
        for (int w = 0; w < WAYS; w++) begin
            if (hit_bits[w]) begin
                result.hit_way = way_t'(w);
            end
        end
        result.victim_way = victim;
        result.victim_dirty = dirty_n[victim][lookup_addr.index];
        result.victim_tag = rd_meta[victim].tag;
    end

endmodule

/* tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;
    import cache_geom_pkg::*;
    import bus_pkg::*;

    localparam logic [31:0] SEED = 32'hb8d0_efa5;
    localparam word_t BASE = 32'h8000_0000;
    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_REQS = 300;
    localparam int TOTAL_REQS = 8 + 4 + 15 + 24 + RANDOM_REQS;
    localparam int CYCLES_PER_REQ = 400;

    typedef struct packed {
        logic is_read;
        logic want_hit;
        word_t data;
        logic [31:0] accept_edge;
    } expect_t;

    logic clk;
    logic resetn;
    logic hold;
    cpu_req_t cpu_req;
    cpu_resp_t cpu_resp;
    mem_req_t mem_req;
    mem_resp_t mem_resp;

    word_t shadow [1024];
    expect_t exp_q [$];
    logic [31:0] cycle;
    logic [31:0] rnd;
    logic [31:0] gap_state;
    logic [1:0] wb_beat;
    int wb_bursts;

    dcache_top dut (
        .clk     (clk),
        .resetn  (resetn),
        .cpu_req (cpu_req),
        .cpu_resp(cpu_resp),
        .mem_req (mem_req),
        .mem_resp(mem_resp)
    );

    mem_model #(.BASE(BASE)) memory (
        .clk     (clk),
        .resetn  (resetn),
        .hold    (hold),
        .mem_req (mem_req),
        .mem_resp(mem_resp)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t initial_word(input word_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic word_t addr_of(input int tag, input int set, input int word);
        return BASE | (word_t'(tag) << 8) | (word_t'(set) << 4) | (word_t'(word) << 2);
    endfunction

    // merges the strobed bytes into the shadow copy, returns what a read sees
    function automatic word_t expected_word(input word_t addr, input strobe_t strobe,
                                            input word_t data);
        logic [9:0] idx;
        idx = addr[11:2];
        for (int b = 0; b < 4; b++) begin
            if (strobe[b]) begin
                shadow[idx][8*b +: 8] = data[8*b +: 8];
            end
        end
        return shadow[idx];
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, want);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic issue(input word_t addr, input strobe_t strobe, input word_t data,
                         input logic want_hit);
        expect_t e;
        cpu_req.valid = 1'b1;
        cpu_req.addr = addr;
        cpu_req.strobe = strobe;
        cpu_req.data = data;
        @(negedge clk);
        while (!cpu_resp.addr_ok) begin
            @(negedge clk);
        end
        // taken at the coming edge
        e.is_read = (strobe == '0);
        e.want_hit = want_hit;
        e.data = expected_word(addr, strobe, data);
        e.accept_edge = cycle + 32'd1;
        exp_q.push_back(e);
        @(posedge clk);
        #1;
        cpu_req.valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        clk = 1'b0;
        cycle = '0;
        forever begin
            #50;
            clk = 1'b1;
            cycle = cycle + 32'd1;
            #50;
            clk = 1'b0;
        end
    end

    // random ready gaps on roughly one beat in four
    initial begin
        gap_state = ~SEED;
        hold = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            gap_state = lcg_next(gap_state);
            hold = (gap_state[31:30] == 2'b00);
        end
    end

    always @(negedge clk) begin
        expect_t e;
        if (!resetn && cpu_resp.data_ok) begin
            if (exp_q.size() == 0) begin
                abort_run("data_ok pulsed while no request was outstanding");
            end else begin
                e = exp_q.pop_front();
                if (e.is_read) begin
                    check("cpu_resp.data", cpu_resp.data, e.data);
                end
                if (e.want_hit) begin
                    check("hit data_ok latency", cycle + 32'd1 - e.accept_edge, 32'd2);
                end
            end
        end
    end

    // each write-back beat must carry the current shadow contents
    always @(negedge clk) begin
        logic [9:0] idx;
        if (resetn) begin
            wb_beat = '0;
            wb_bursts = 0;
        end else if (mem_req.valid && mem_req.is_write && mem_resp.ready) begin
            idx = {mem_req.line_addr[7:0], wb_beat};
            check("mem_req.line_addr", {mem_req.line_addr, 4'h0} & 32'hffff_f000, BASE);
            check("mem_req.data", mem_req.data, shadow[idx]);
            wb_beat = wb_beat + 2'd1;
            if (mem_resp.last) begin
                wb_beat = '0;
                wb_bursts++;
            end
        end
    end

    initial begin
        repeat (RESET_CYCLES + CYCLES_PER_REQ * TOTAL_REQS) @(posedge clk);
        abort_run($sformatf("watchdog expired after %0d cycles, the cache stopped answering",
                            cycle));
    end

    initial begin
        word_t a;
        strobe_t s;
        word_t hot [3];
        resetn = 1'b1;
        cpu_req = '0;
        rnd = SEED;
        for (int i = 0; i < 1024; i++) begin
            shadow[i] = initial_word(BASE | (word_t'(i) << 2));
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        resetn = 1'b0;
        check("cpu_resp.addr_ok", {31'd0, cpu_resp.addr_ok}, 32'd1);
        check("cpu_resp.data_ok", {31'd0, cpu_resp.data_ok}, 32'd0);
        check("mem_req.valid", {31'd0, mem_req.valid}, 32'd0);

        // untouched lines come straight from memory
        for (int set = 0; set < 4; set++) begin
            issue(addr_of(8, set, 0), '0, '0, 1'b0);
            issue(addr_of(8, set, 3), '0, '0, 1'b0);
        end
        wait_idle();

        // partial writes merge with the old word
        issue(addr_of(9, 2, 1), 4'b0101, 32'hdead_beef, 1'b0);
        issue(addr_of(9, 2, 1), '0, '0, 1'b0);
        issue(addr_of(9, 2, 1), 4'b1000, 32'h1234_5678, 1'b0);
        issue(addr_of(9, 2, 1), '0, '0, 1'b0);
        wait_idle();

        hot[0] = addr_of(10, 8, 0);
        hot[1] = addr_of(10, 9, 0);
        hot[2] = addr_of(11, 8, 0);
        for (int i = 0; i < 3; i++) begin
            issue(hot[i], '0, '0, 1'b0);
        end
        wait_idle();
        // hits that write then read one word back to back
        for (int i = 0; i < 12; i++) begin
            a = hot[(i / 2) % 3] + (word_t'((i / 2) % 4) << 2);
            s = (i % 2 == 0) ? strobe_t'(4'hf >> (i % 4)) : '0;
            rnd = lcg_next(rnd);
            issue(a, s, rnd, 1'b1);
        end
        wait_idle();

        // three tags in set 5
        for (int t = 0; t < 3; t++) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                rnd = lcg_next(rnd);
                issue(addr_of(4 + t, 5, w), (w == 1) ? 4'b0011 : 4'b1111, rnd, 1'b0);
            end
        end
        for (int t = 0; t < 3; t++) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                issue(addr_of(4 + t, 5, w), '0, '0, 1'b0);
            end
        end
        wait_idle();

        for (int i = 0; i < RANDOM_REQS; i++) begin
            rnd = lcg_next(rnd);
            a = BASE | {22'd0, rnd[31:24], 2'b00};
            s = rnd[23] ? strobe_t'(rnd[22:19]) : '0;
            rnd = lcg_next(rnd);
            issue(a, s, rnd, 1'b0);
        end
        wait_idle();

        // a stray data_ok after the last response still reaches the monitor
        repeat (4) @(posedge clk);
        if (wb_bursts == 0) begin
            abort_run("no write-back burst was seen, dirty lines were never evicted");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule
